//--- Bender.yml
package:
  name: tnoc_axi_bridge

export_include_dirs:
  - design

sources:
  - files:
      - design/tnoc_pkg.sv
      - design/tnoc_flit_if.sv
      - design/tnoc_address_decoder.sv
      - design/tnoc_axi_slave_adapter.sv
      - design/tnoc_axi_master_adapter.sv
      - design/tnoc_fabric.sv
      - design/tnoc_axi_bridge.sv
  - target: test
    files:
      - tests/tnoc_axi_bridge_tb.sv

//--- design/tnoc_address_decoder.sv
`timescale 1ns/1ps
`include "tnoc_defines.svh"

module tnoc_address_decoder (
  input  logic [`TNOC_ADDR_W-1:0] i_address,
  output logic [`TNOC_NODE_W-1:0] o_dest_id,
  output logic                    o_decode_error
);
  // Top two address bits pick the target node
  always_comb begin
    o_dest_id      = '0;
    o_decode_error = 1'b0;
    case (i_address[`TNOC_ADDR_W-1 -: 2])
      2'd0: begin
        o_dest_id = `TNOC_NODE_W'(1);
      end
      2'd1: begin
        o_dest_id = `TNOC_NODE_W'(2);
      end
      default: begin
        o_decode_error = 1'b1;
      end
    endcase
  end
endmodule

//--- design/tnoc_axi_bridge.sv
`timescale 1ns/1ps
`include "tnoc_defines.svh"

module tnoc_axi_bridge (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  logic [`TNOC_ID_W-1:0]   i_awid,
  input  logic [`TNOC_ADDR_W-1:0] i_awaddr,
  input  logic                    i_wvalid,
  output logic                    o_wready,
  input  logic [`TNOC_DATA_W-1:0] i_wdata,
  input  logic [`TNOC_STRB_W-1:0] i_wstrb,
  output logic                    o_bvalid,
  input  logic                    i_bready,
  output logic [`TNOC_ID_W-1:0]   o_bid,
  output logic [1:0]              o_bresp,
  input  logic                    i_arvalid,
  output logic                    o_arready,
  input  logic [`TNOC_ID_W-1:0]   i_arid,
  input  logic [`TNOC_ADDR_W-1:0] i_araddr,
  output logic                    o_rvalid,
  input  logic                    i_rready,
  output logic [`TNOC_ID_W-1:0]   o_rid,
  output logic [`TNOC_DATA_W-1:0] o_rdata,
  output logic [1:0]              o_rresp,
  output logic                    o_m_awvalid [`TNOC_TARGETS],
  input  logic                    i_m_awready [`TNOC_TARGETS],
  output logic [`TNOC_ID_W-1:0]   o_m_awid    [`TNOC_TARGETS],
  output logic [`TNOC_ADDR_W-1:0] o_m_awaddr  [`TNOC_TARGETS],
  output logic                    o_m_wvalid  [`TNOC_TARGETS],
  input  logic                    i_m_wready  [`TNOC_TARGETS],
  output logic [`TNOC_DATA_W-1:0] o_m_wdata   [`TNOC_TARGETS],
  output logic [`TNOC_STRB_W-1:0] o_m_wstrb   [`TNOC_TARGETS],
  input  logic                    i_m_bvalid  [`TNOC_TARGETS],
  output logic                    o_m_bready  [`TNOC_TARGETS],
  input  logic [`TNOC_ID_W-1:0]   i_m_bid     [`TNOC_TARGETS],
  input  logic [1:0]              i_m_bresp   [`TNOC_TARGETS],
  output logic                    o_m_arvalid [`TNOC_TARGETS],
  input  logic                    i_m_arready [`TNOC_TARGETS],
  output logic [`TNOC_ID_W-1:0]   o_m_arid    [`TNOC_TARGETS],
  output logic [`TNOC_ADDR_W-1:0] o_m_araddr  [`TNOC_TARGETS],
  input  logic                    i_m_rvalid  [`TNOC_TARGETS],
  output logic                    o_m_rready  [`TNOC_TARGETS],
  input  logic [`TNOC_ID_W-1:0]   i_m_rid     [`TNOC_TARGETS],
  input  logic [`TNOC_DATA_W-1:0] i_m_rdata   [`TNOC_TARGETS],
  input  logic [1:0]              i_m_rresp   [`TNOC_TARGETS]
);
  tnoc_flit_if req_from_ini ();
  tnoc_flit_if rsp_to_ini ();
  tnoc_flit_if req_to_tgt   [`TNOC_TARGETS] ();
  tnoc_flit_if rsp_from_tgt [`TNOC_TARGETS] ();

  // AXI port names of the initiator side match one to one
  tnoc_axi_slave_adapter u_slave_adapter (
    .*,
    .req_if (req_from_ini ),
    .rsp_if (rsp_to_ini   )
  );

  tnoc_fabric u_fabric (
    .i_clk      (i_clk        ),
    .i_arst_n   (i_arst_n     ),
    .req_in_if  (req_from_ini ),
    .rsp_out_if (rsp_to_ini   ),
    .req_out_if (req_to_tgt   ),
    .rsp_in_if  (rsp_from_tgt )
  );

  for (genvar i = 0; i < `TNOC_TARGETS; i++) begin : g_target
    tnoc_axi_master_adapter #(
      .NODE_ID (`TNOC_NODE_W'(i + 1))
    ) u_master_adapter (
      .i_clk       (i_clk           ),
      .i_arst_n    (i_arst_n        ),
      .req_if      (req_to_tgt[i]   ),
      .rsp_if      (rsp_from_tgt[i] ),
      .o_m_awvalid (o_m_awvalid[i]  ),
      .i_m_awready (i_m_awready[i]  ),
      .o_m_awid    (o_m_awid[i]     ),
      .o_m_awaddr  (o_m_awaddr[i]   ),
      .o_m_wvalid  (o_m_wvalid[i]   ),
      .i_m_wready  (i_m_wready[i]   ),
      .o_m_wdata   (o_m_wdata[i]    ),
      .o_m_wstrb   (o_m_wstrb[i]    ),
      .i_m_bvalid  (i_m_bvalid[i]   ),
      .o_m_bready  (o_m_bready[i]   ),
      .i_m_bid     (i_m_bid[i]      ),
      .i_m_bresp   (i_m_bresp[i]    ),
      .o_m_arvalid (o_m_arvalid[i]  ),
      .i_m_arready (i_m_arready[i]  ),
      .o_m_arid    (o_m_arid[i]     ),
      .o_m_araddr  (o_m_araddr[i]   ),
      .i_m_rvalid  (i_m_rvalid[i]   ),
      .o_m_rready  (o_m_rready[i]   ),
      .i_m_rid     (i_m_rid[i]      ),
      .i_m_rdata   (i_m_rdata[i]    ),
      .i_m_rresp   (i_m_rresp[i]    )
    );
  end
endmodule

//--- design/tnoc_axi_master_adapter.sv
`timescale 1ns/1ps
`include "tnoc_defines.svh"

module tnoc_axi_master_adapter #(
  parameter logic [`TNOC_NODE_W-1:0] NODE_ID = `TNOC_NODE_W'(1)
)(
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  tnoc_flit_if.receiver           req_if,
  tnoc_flit_if.sender             rsp_if,
  output logic                    o_m_awvalid,
  input  logic                    i_m_awready,
  output logic [`TNOC_ID_W-1:0]   o_m_awid,
  output logic [`TNOC_ADDR_W-1:0] o_m_awaddr,
  output logic                    o_m_wvalid,
  input  logic                    i_m_wready,
  output logic [`TNOC_DATA_W-1:0] o_m_wdata,
  output logic [`TNOC_STRB_W-1:0] o_m_wstrb,
  input  logic                    i_m_bvalid,
  output logic                    o_m_bready,
  input  logic [`TNOC_ID_W-1:0]   i_m_bid,
  input  logic [1:0]              i_m_bresp,
  output logic                    o_m_arvalid,
  input  logic                    i_m_arready,
  output logic [`TNOC_ID_W-1:0]   o_m_arid,
  output logic [`TNOC_ADDR_W-1:0] o_m_araddr,
  input  logic                    i_m_rvalid,
  output logic                    o_m_rready,
  input  logic [`TNOC_ID_W-1:0]   i_m_rid,
  input  logic [`TNOC_DATA_W-1:0] i_m_rdata,
  input  logic [1:0]              i_m_rresp
);
  import tnoc_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_SEND
  } state_e;

  state_e     state;
  tnoc_flit_t req_q;
  tnoc_flit_t rsp_q;
  logic       req_take;
  logic       issue_done;
  logic       b_take;
  logic       r_take;

  assign req_if.ready = (state == ST_IDLE);
  assign req_take     = req_if.valid && req_if.ready;

  // All address and data channels handshaken or never raised
  assign issue_done = (!o_m_awvalid || i_m_awready) && (!o_m_wvalid || i_m_wready) &&
                      (!o_m_arvalid || i_m_arready);

  assign o_m_bready = (state == ST_WAIT) && req_q.header.is_write;
  assign o_m_rready = (state == ST_WAIT) && !req_q.header.is_write;
  assign b_take     = i_m_bvalid && o_m_bready;
  assign r_take     = i_m_rvalid && o_m_rready;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state       <= ST_IDLE;
      o_m_awvalid <= 1'b0;
      o_m_wvalid  <= 1'b0;
      o_m_arvalid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_take) begin
            state       <= ST_ISSUE;
            o_m_awvalid <= req_if.flit.header.is_write;
            o_m_wvalid  <= req_if.flit.header.is_write;
            o_m_arvalid <= !req_if.flit.header.is_write;
          end
        end
        ST_ISSUE: begin
          if (i_m_awready) begin
            o_m_awvalid <= 1'b0;
          end
          if (i_m_wready) begin
            o_m_wvalid <= 1'b0;
          end
          if (i_m_arready) begin
            o_m_arvalid <= 1'b0;
          end
          if (issue_done) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (b_take || r_take) begin
            state <= ST_SEND;
          end
        end
        default: begin
          if (rsp_if.ready) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_take) begin
      req_q <= req_if.flit;
    end
    // Answer goes back to the node that sent the request
    if (b_take || r_take) begin
      rsp_q.header.is_response <= 1'b1;
      rsp_q.header.is_write    <= req_q.header.is_write;
      rsp_q.header.dest_id     <= req_q.header.src_id;
      rsp_q.header.src_id      <= NODE_ID;
      rsp_q.header.axi_id      <= b_take ? i_m_bid : i_m_rid;
      rsp_q.payload.rsp.data   <= b_take ? '0 : i_m_rdata;
      rsp_q.payload.rsp.resp   <= tnoc_resp_e'(b_take ? i_m_bresp : i_m_rresp);
      rsp_q.payload.rsp.pad    <= '0;
    end
  end

  assign o_m_awid   = req_q.header.axi_id;
  assign o_m_awaddr = req_q.payload.req.address;
  assign o_m_wdata  = req_q.payload.req.data;
  assign o_m_wstrb  = req_q.payload.req.strobe;
  assign o_m_arid   = req_q.header.axi_id;
  assign o_m_araddr = req_q.payload.req.address;

  assign rsp_if.valid = (state == ST_SEND);
  assign rsp_if.flit  = rsp_q;
endmodule

//--- design/tnoc_axi_slave_adapter.sv
`timescale 1ns/1ps
`include "tnoc_defines.svh"

module tnoc_axi_slave_adapter (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  logic [`TNOC_ID_W-1:0]   i_awid,
  input  logic [`TNOC_ADDR_W-1:0] i_awaddr,
  input  logic                    i_wvalid,
  output logic                    o_wready,
  input  logic [`TNOC_DATA_W-1:0] i_wdata,
  input  logic [`TNOC_STRB_W-1:0] i_wstrb,
  output logic                    o_bvalid,
  input  logic                    i_bready,
  output logic [`TNOC_ID_W-1:0]   o_bid,
  output logic [1:0]              o_bresp,
  input  logic                    i_arvalid,
  output logic                    o_arready,
  input  logic [`TNOC_ID_W-1:0]   i_arid,
  input  logic [`TNOC_ADDR_W-1:0] i_araddr,
  output logic                    o_rvalid,
  input  logic                    i_rready,
  output logic [`TNOC_ID_W-1:0]   o_rid,
  output logic [`TNOC_DATA_W-1:0] o_rdata,
  output logic [1:0]              o_rresp,
  tnoc_flit_if.sender             req_if,
  tnoc_flit_if.receiver           rsp_if
);
  import tnoc_pkg::*;

  logic [`TNOC_NODE_W-1:0] aw_dest_id;
  logic [`TNOC_NODE_W-1:0] ar_dest_id;
  logic                    aw_error;
  logic                    ar_error;
  logic                    req_free;
  logic                    accept_write;
  logic                    accept_read;
  logic                    req_load;
  logic                    err_take;
  logic                    rsp_take;
  logic                    req_valid;
  tnoc_flit_t              req_flit;
  tnoc_flit_t              next_flit;

  tnoc_address_decoder u_write_decoder (
    .i_address      (i_awaddr   ),
    .o_dest_id      (aw_dest_id ),
    .o_decode_error (aw_error   )
  );

  tnoc_address_decoder u_read_decoder (
    .i_address      (i_araddr   ),
    .o_dest_id      (ar_dest_id ),
    .o_decode_error (ar_error   )
  );

  // Write needs AW and W together and wins over a read in the same cycle
  assign req_free     = !req_valid || req_if.ready;
  assign accept_write = i_awvalid && i_wvalid && (aw_error ? !o_bvalid : req_free);
  assign accept_read  = i_arvalid && !accept_write && (ar_error ? !o_rvalid : req_free);
  assign req_load     = (accept_write && !aw_error) || (accept_read && !ar_error);
  assign err_take     = (accept_write && aw_error) || (accept_read && ar_error);

  assign o_awready = accept_write;
  assign o_wready  = accept_write;
  assign o_arready = accept_read;

  always_comb begin
    next_flit                        = '0;
    next_flit.header.is_write        = accept_write;
    next_flit.header.dest_id         = accept_write ? aw_dest_id : ar_dest_id;
    next_flit.header.axi_id          = accept_write ? i_awid : i_arid;
    next_flit.payload.req.address    = accept_write ? i_awaddr : i_araddr;
    next_flit.payload.req.data       = i_wdata;
    next_flit.payload.req.strobe     = i_wstrb;
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      req_valid <= 1'b0;
    end else if (req_load) begin
      req_valid <= 1'b1;
    end else if (req_if.ready) begin
      req_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_load) begin
      req_flit <= next_flit;
    end
  end

  assign req_if.valid = req_valid;
  assign req_if.flit  = req_flit;

  // No new response while one waits on B or R, or a local error is loading
  assign rsp_if.ready = !o_bvalid && !o_rvalid && !err_take;
  assign rsp_take     = rsp_if.valid && rsp_if.ready;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_bvalid <= 1'b0;
      o_rvalid <= 1'b0;
    end else begin
      if ((accept_write && aw_error) || (rsp_take && rsp_if.flit.header.is_write)) begin
        o_bvalid <= 1'b1;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
      if ((accept_read && ar_error) || (rsp_take && !rsp_if.flit.header.is_write)) begin
        o_rvalid <= 1'b1;
      end else if (i_rready) begin
        o_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept_write && aw_error) begin
      o_bid   <= i_awid;
      o_bresp <= TNOC_RESP_DECERR;
    end else if (rsp_take && rsp_if.flit.header.is_write) begin
      o_bid   <= rsp_if.flit.header.axi_id;
      o_bresp <= rsp_if.flit.payload.rsp.resp;
    end
    if (accept_read && ar_error) begin
      o_rid   <= i_arid;
      o_rdata <= '0;
      o_rresp <= TNOC_RESP_DECERR;
    end else if (rsp_take && !rsp_if.flit.header.is_write) begin
      o_rid   <= rsp_if.flit.header.axi_id;
      o_rdata <= rsp_if.flit.payload.rsp.data;
      o_rresp <= rsp_if.flit.payload.rsp.resp;
    end
  end
endmodule

//--- design/tnoc_defines.svh
`ifndef TNOC_DEFINES_SVH
`define TNOC_DEFINES_SVH

// AXI side widths
`define TNOC_ADDR_W   32
`define TNOC_DATA_W   32
`define TNOC_STRB_W   4
`define TNOC_ID_W     4

// Fabric side widths and sizes
`define TNOC_NODE_W   2
`define TNOC_TARGETS  2

`endif

//--- design/tnoc_fabric.sv
`timescale 1ns/1ps
`include "tnoc_defines.svh"

module tnoc_fabric (
  input  logic          i_clk,
  input  logic          i_arst_n,
  tnoc_flit_if.receiver req_in_if,
  tnoc_flit_if.sender   rsp_out_if,
  tnoc_flit_if.sender   req_out_if [`TNOC_TARGETS],
  tnoc_flit_if.receiver rsp_in_if  [`TNOC_TARGETS]
);
  import tnoc_pkg::*;

  localparam int SEL_W = (`TNOC_TARGETS > 1) ? $clog2(`TNOC_TARGETS) : 1;

  logic [`TNOC_NODE_W-1:0]  tgt_idx;
  logic [`TNOC_TARGETS-1:0] req_sel;
  logic [`TNOC_TARGETS-1:0] tgt_ready;
  logic [`TNOC_TARGETS-1:0] rsp_valid;
  tnoc_flit_t               rsp_flit [`TNOC_TARGETS];
  logic [SEL_W-1:0]         last_grant;
  logic [SEL_W-1:0]         grant_idx;
  logic                     grant_valid;
  logic                     out_load;
  logic                     out_valid;
  tnoc_flit_t               out_flit;

  // Node ids start at 1 for target 0
  assign tgt_idx = req_in_if.flit.header.dest_id - 1'b1;

  for (genvar i = 0; i < `TNOC_TARGETS; i++) begin : g_port
    assign req_sel[i]          = (tgt_idx == `TNOC_NODE_W'(i));
    assign req_out_if[i].valid = req_in_if.valid && req_sel[i];
    assign req_out_if[i].flit  = req_in_if.flit;
    assign tgt_ready[i]        = req_out_if[i].ready;

    assign rsp_valid[i]       = rsp_in_if[i].valid;
    assign rsp_flit[i]        = rsp_in_if[i].flit;
    assign rsp_in_if[i].ready = out_load && (grant_idx == SEL_W'(i));
  end

  assign req_in_if.ready = |(req_sel & tgt_ready);

  // Round robin where the port after the last grant has top priority
  always_comb begin
    int idx;
    grant_valid = 1'b0;
    grant_idx   = last_grant;
    for (int k = `TNOC_TARGETS; k >= 1; k--) begin
      idx = (int'(last_grant) + k) % `TNOC_TARGETS;
      if (rsp_valid[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = SEL_W'(idx);
      end
    end
  end

  assign out_load = grant_valid && (!out_valid || rsp_out_if.ready);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      out_valid  <= 1'b0;
      last_grant <= '0;
    end else if (out_load) begin
      out_valid  <= 1'b1;
      last_grant <= grant_idx;
    end else if (rsp_out_if.ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (out_load) begin
      out_flit <= rsp_flit[grant_idx];
    end
  end

  assign rsp_out_if.valid = out_valid;
  assign rsp_out_if.flit  = out_flit;
endmodule

//--- design/tnoc_flit_if.sv
`timescale 1ns/1ps

interface tnoc_flit_if;
  import tnoc_pkg::*;

  logic       valid;
  logic       ready;
  tnoc_flit_t flit;

  modport sender (
    output valid,
    input  ready,
    output flit
  );

  modport receiver (
    input  valid,
    output ready,
    input  flit
  );
endinterface

//--- design/tnoc_pkg.sv
`include "tnoc_defines.svh"

package tnoc_pkg;

  typedef enum logic [1:0] {
    TNOC_RESP_OKAY   = 2'd0,
    TNOC_RESP_EXOKAY = 2'd1,
    TNOC_RESP_SLVERR = 2'd2,
    TNOC_RESP_DECERR = 2'd3
  } tnoc_resp_e;

  typedef struct packed {
    logic                    is_response;
    logic                    is_write;
    logic [`TNOC_NODE_W-1:0] dest_id;
    logic [`TNOC_NODE_W-1:0] src_id;
    logic [`TNOC_ID_W-1:0]   axi_id;
  } tnoc_header_t;

  typedef struct packed {
    logic [`TNOC_ADDR_W-1:0] address;
    logic [`TNOC_DATA_W-1:0] data;
    logic [`TNOC_STRB_W-1:0] strobe;
  } tnoc_req_payload_t;

  // Padded out to the request view width
  typedef struct packed {
    logic [`TNOC_DATA_W-1:0]              data;
    tnoc_resp_e                           resp;
    logic [`TNOC_ADDR_W+`TNOC_STRB_W-3:0] pad;
  } tnoc_rsp_payload_t;

  typedef union packed {
    tnoc_req_payload_t req;
    tnoc_rsp_payload_t rsp;
  } tnoc_payload_u;

  typedef struct packed {
    tnoc_header_t  header;
    tnoc_payload_u payload;
  } tnoc_flit_t;

endpackage

//--- tests/tnoc_axi_bridge_tb.sv
`timescale 1ns/1ps
`include "tnoc_defines.svh"

module tnoc_axi_bridge_tb;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_TXNS     = 16;
  // Worst case per transaction including the back-pressure hold
  localparam int TXN_CYCLES   = 40;

  logic                    i_clk;
  logic                    i_arst_n;
  logic                    i_awvalid;
  logic                    o_awready;
  logic [`TNOC_ID_W-1:0]   i_awid;
  logic [`TNOC_ADDR_W-1:0] i_awaddr;
  logic                    i_wvalid;
  logic                    o_wready;
  logic [`TNOC_DATA_W-1:0] i_wdata;
  logic [`TNOC_STRB_W-1:0] i_wstrb;
  logic                    o_bvalid;
  logic                    i_bready;
  logic [`TNOC_ID_W-1:0]   o_bid;
  logic [1:0]              o_bresp;
  logic                    i_arvalid;
  logic                    o_arready;
  logic [`TNOC_ID_W-1:0]   i_arid;
  logic [`TNOC_ADDR_W-1:0] i_araddr;
  logic                    o_rvalid;
  logic                    i_rready;
  logic [`TNOC_ID_W-1:0]   o_rid;
  logic [`TNOC_DATA_W-1:0] o_rdata;
  logic [1:0]              o_rresp;
  logic                    o_m_awvalid [`TNOC_TARGETS];
  logic                    i_m_awready [`TNOC_TARGETS];
  logic [`TNOC_ID_W-1:0]   o_m_awid    [`TNOC_TARGETS];
  logic [`TNOC_ADDR_W-1:0] o_m_awaddr  [`TNOC_TARGETS];
  logic                    o_m_wvalid  [`TNOC_TARGETS];
  logic                    i_m_wready  [`TNOC_TARGETS];
  logic [`TNOC_DATA_W-1:0] o_m_wdata   [`TNOC_TARGETS];
  logic [`TNOC_STRB_W-1:0] o_m_wstrb   [`TNOC_TARGETS];
  logic                    i_m_bvalid  [`TNOC_TARGETS];
  logic                    o_m_bready  [`TNOC_TARGETS];
  logic [`TNOC_ID_W-1:0]   i_m_bid     [`TNOC_TARGETS];
  logic [1:0]              i_m_bresp   [`TNOC_TARGETS];
  logic                    o_m_arvalid [`TNOC_TARGETS];
  logic                    i_m_arready [`TNOC_TARGETS];
  logic [`TNOC_ID_W-1:0]   o_m_arid    [`TNOC_TARGETS];
  logic [`TNOC_ADDR_W-1:0] o_m_araddr  [`TNOC_TARGETS];
  logic                    i_m_rvalid  [`TNOC_TARGETS];
  logic                    o_m_rready  [`TNOC_TARGETS];
  logic [`TNOC_ID_W-1:0]   i_m_rid     [`TNOC_TARGETS];
  logic [`TNOC_DATA_W-1:0] i_m_rdata   [`TNOC_TARGETS];
  logic [1:0]              i_m_rresp   [`TNOC_TARGETS];

  // What each target model saw on its last handshakes
  logic [`TNOC_ADDR_W-1:0] seen_awaddr  [`TNOC_TARGETS];
  logic [`TNOC_DATA_W-1:0] seen_wdata   [`TNOC_TARGETS];
  logic [`TNOC_STRB_W-1:0] seen_wstrb   [`TNOC_TARGETS];
  logic [`TNOC_ID_W-1:0]   seen_awid    [`TNOC_TARGETS];
  logic [`TNOC_ADDR_W-1:0] seen_araddr  [`TNOC_TARGETS];
  logic [`TNOC_ID_W-1:0]   seen_arid    [`TNOC_TARGETS];
  int                      aw_count     [`TNOC_TARGETS] = '{default: 0};
  int                      ar_count     [`TNOC_TARGETS] = '{default: 0};
  int                      valid_cycles [`TNOC_TARGETS] = '{default: 0};
  int                      errors = 0;
  logic [31:0]             lfsr_state = 32'he677;

  tnoc_axi_bridge tnoc_axi_bridge_inst (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two LFSR steps give a delay of 0 to 3 cycles
  task automatic random_delay(output int delay);
    delay = 0;
    repeat (2) begin
      lfsr_state = lfsr_next(lfsr_state);
      delay      = (delay << 1) | int'(lfsr_state[0]);
    end
  endtask

  // Contents of a target word that was never written
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h3c5a_a5c3;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic logic [31:0] target_addr(input int t, input logic [29:0] offset);
    return {2'(t), offset};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    assert (got === expected) else begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
    end
  endtask

  task automatic confirm(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  // Behavioral targets with small tagged memories
  for (genvar t = 0; t < `TNOC_TARGETS; t++) begin : g_target_model
    logic [31:0] mem_data [16];
    logic [31:0] mem_addr [16];
    logic        mem_used [16] = '{default: 1'b0};

    initial begin
      int          delay;
      logic [31:0] addr;
      logic [3:0]  id;
      logic [3:0]  idx;
      logic [31:0] word;
      forever begin
        @(posedge i_clk);
        if (o_m_awvalid[t]) begin
          random_delay(delay);
          repeat (delay) @(posedge i_clk);
          i_m_awready[t] <= 1'b1;
          i_m_wready[t]  <= 1'b1;
          @(posedge i_clk);
          i_m_awready[t] <= 1'b0;
          i_m_wready[t]  <= 1'b0;
          compare_value($sformatf("o_m_wvalid[%0d]", t), o_m_wvalid[t], 1);
          addr           = o_m_awaddr[t];
          id             = o_m_awid[t];
          seen_awaddr[t] = addr;
          seen_awid[t]   = id;
          seen_wdata[t]  = o_m_wdata[t];
          seen_wstrb[t]  = o_m_wstrb[t];
          aw_count[t]++;
          idx  = addr[5:2];
          word = (mem_used[idx] && mem_addr[idx] == addr) ? mem_data[idx] : fill_word(addr);
          mem_data[idx] = merge_bytes(word, o_m_wdata[t], o_m_wstrb[t]);
          mem_addr[idx] = addr;
          mem_used[idx] = 1'b1;
          random_delay(delay);
          repeat (delay) @(posedge i_clk);
          i_m_bvalid[t] <= 1'b1;
          i_m_bid[t]    <= id;
          i_m_bresp[t]  <= 2'd0;
          do @(posedge i_clk); while (!o_m_bready[t]);
          i_m_bvalid[t] <= 1'b0;
        end else if (o_m_arvalid[t]) begin
          random_delay(delay);
          repeat (delay) @(posedge i_clk);
          i_m_arready[t] <= 1'b1;
          @(posedge i_clk);
          i_m_arready[t] <= 1'b0;
          addr           = o_m_araddr[t];
          id             = o_m_arid[t];
          seen_araddr[t] = addr;
          seen_arid[t]   = id;
          ar_count[t]++;
          idx  = addr[5:2];
          word = (mem_used[idx] && mem_addr[idx] == addr) ? mem_data[idx] : fill_word(addr);
          random_delay(delay);
          repeat (delay) @(posedge i_clk);
          i_m_rvalid[t] <= 1'b1;
          i_m_rid[t]    <= id;
          i_m_rdata[t]  <= word;
          i_m_rresp[t]  <= 2'd0;
          do @(posedge i_clk); while (!o_m_rready[t]);
          i_m_rvalid[t] <= 1'b0;
        end
      end
    end
  end

  always @(posedge i_clk) begin
    for (int t = 0; t < `TNOC_TARGETS; t++) begin
      if (o_m_awvalid[t] || o_m_arvalid[t]) begin
        valid_cycles[t] <= valid_cycles[t] + 1;
      end
    end
  end

  task automatic send_write(input logic [3:0] id, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
    i_awvalid <= 1'b1;
    i_wvalid  <= 1'b1;
    i_awid    <= id;
    i_awaddr  <= addr;
    i_wdata   <= data;
    i_wstrb   <= strb;
    do @(posedge i_clk); while (!o_awready);
    compare_value("o_wready", o_wready, 1);
    i_awvalid <= 1'b0;
    i_wvalid  <= 1'b0;
  endtask

  task automatic send_read(input logic [3:0] id, input logic [31:0] addr);
    i_arvalid <= 1'b1;
    i_arid    <= id;
    i_araddr  <= addr;
    do @(posedge i_clk); while (!o_arready);
    i_arvalid <= 1'b0;
  endtask

  task automatic take_b(output logic [3:0] id, output logic [1:0] resp);
    i_bready <= 1'b1;
    do @(posedge i_clk); while (!o_bvalid);
    id   = o_bid;
    resp = o_bresp;
    i_bready <= 1'b0;
  endtask

  task automatic take_r(output logic [3:0] id, output logic [31:0] data,
                        output logic [1:0] resp);
    i_rready <= 1'b1;
    do @(posedge i_clk); while (!o_rvalid);
    id   = o_rid;
    data = o_rdata;
    resp = o_rresp;
    i_rready <= 1'b0;
  endtask

  task automatic test_reset_state();
    compare_value("o_bvalid", o_bvalid, 0);
    compare_value("o_rvalid", o_rvalid, 0);
    for (int t = 0; t < `TNOC_TARGETS; t++) begin
      compare_value($sformatf("o_m_awvalid[%0d]", t), o_m_awvalid[t], 0);
      compare_value($sformatf("o_m_wvalid[%0d]", t), o_m_wvalid[t], 0);
      compare_value($sformatf("o_m_arvalid[%0d]", t), o_m_arvalid[t], 0);
      compare_value($sformatf("o_m_bready[%0d]", t), o_m_bready[t], 0);
      compare_value($sformatf("o_m_rready[%0d]", t), o_m_rready[t], 0);
    end
  endtask

  task automatic test_write_read();
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rdata;
    logic [3:0]  id;
    logic [1:0]  resp;
    for (int t = 0; t < `TNOC_TARGETS; t++) begin
      addr = target_addr(t, 30'h10);
      data = 32'ha5c3_0000 | t;
      send_write(4'(1 + t), addr, data, 4'b0110);
      take_b(id, resp);
      compare_value("o_bid", id, 1 + t);
      compare_value("o_bresp", resp, 0);
      send_read(4'(9 + t), addr);
      take_r(id, rdata, resp);
      compare_value("o_rid", id, 9 + t);
      compare_value("o_rresp", resp, 0);
      compare_value("o_rdata", rdata, merge_bytes(fill_word(addr), data, 4'b0110));
    end
  endtask

  task automatic test_decode_error();
    int          idle_before [`TNOC_TARGETS];
    logic [31:0] rdata;
    logic [3:0]  id;
    logic [1:0]  resp;
    idle_before = valid_cycles;
    for (int sel = 2; sel <= 3; sel++) begin
      send_write(4'(sel), {2'(sel), 30'h100}, 32'hdead_beef, 4'hf);
      take_b(id, resp);
      compare_value("o_bid", id, sel);
      compare_value("o_bresp", resp, 3);
      send_read(4'(sel + 4), {2'(sel), 30'h104});
      take_r(id, rdata, resp);
      compare_value("o_rid", id, sel + 4);
      compare_value("o_rresp", resp, 3);
    end
    for (int t = 0; t < `TNOC_TARGETS; t++) begin
      confirm(valid_cycles[t] == idle_before[t],
              $sformatf("Target %0d saw a request for an unmapped address", t));
    end
  endtask

  task automatic test_forwarding();
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rdata;
    logic [3:0]  id;
    logic [1:0]  resp;
    int          other;
    int          idle_before;
    int          aw_before;
    int          ar_before;
    for (int t = 0; t < `TNOC_TARGETS; t++) begin
      other       = (t + 1) % `TNOC_TARGETS;
      addr        = target_addr(t, 30'h20);
      data        = 32'h1357_9bdf ^ addr;
      idle_before = valid_cycles[other];
      aw_before   = aw_count[t];
      ar_before   = ar_count[t];
      send_write(4'(6 + t), addr, data, 4'b1011);
      take_b(id, resp);
      compare_value($sformatf("o_m_awaddr[%0d]", t), seen_awaddr[t], addr);
      compare_value($sformatf("o_m_wdata[%0d]", t), seen_wdata[t], data);
      compare_value($sformatf("o_m_wstrb[%0d]", t), seen_wstrb[t], 4'b1011);
      compare_value($sformatf("o_m_awid[%0d]", t), seen_awid[t], 6 + t);
      compare_value("AW handshake count", aw_count[t], aw_before + 1);
      send_read(4'(12 + t), addr);
      take_r(id, rdata, resp);
      compare_value($sformatf("o_m_araddr[%0d]", t), seen_araddr[t], addr);
      compare_value($sformatf("o_m_arid[%0d]", t), seen_arid[t], 12 + t);
      compare_value("AR handshake count", ar_count[t], ar_before + 1);
      confirm(valid_cycles[other] == idle_before,
              $sformatf("Target %0d was not idle during a request to target %0d", other, t));
    end
  endtask

  task automatic test_outstanding();
    logic [3:0] id_first;
    logic [3:0] id_second;
    logic [1:0] resp_first;
    logic [1:0] resp_second;
    send_write(4'h3, target_addr(0, 30'h28), 32'h0f0f_1111, 4'hf);
    send_write(4'h5, target_addr(1, 30'h28), 32'hf0f0_2222, 4'hf);
    take_b(id_first, resp_first);
    take_b(id_second, resp_second);
    confirm((id_first == 4'h3 && id_second == 4'h5) || (id_first == 4'h5 && id_second == 4'h3),
            "Outstanding writes did not return ids 3 and 5 once each");
    compare_value("o_bresp", resp_first, 0);
    compare_value("o_bresp", resp_second, 0);
  endtask

  task automatic test_backpressure();
    logic [31:0] addr;
    logic [3:0]  held_id;
    logic [1:0]  held_resp;
    logic [31:0] held_data;
    addr = target_addr(1, 30'h34);
    send_write(4'h7, addr, 32'h0bad_f00d, 4'hf);
    do @(posedge i_clk); while (!o_bvalid);
    held_id   = o_bid;
    held_resp = o_bresp;
    compare_value("o_bid", held_id, 4'h7);
    repeat (6) begin
      @(posedge i_clk);
      confirm(o_bvalid, "bvalid dropped while bready was low");
      compare_value("o_bid", o_bid, held_id);
      compare_value("o_bresp", o_bresp, held_resp);
    end
    i_bready <= 1'b1;
    @(posedge i_clk);
    i_bready <= 1'b0;
    @(posedge i_clk);
    confirm(!o_bvalid, "bvalid stayed high after the B handshake");
    send_read(4'h8, addr);
    do @(posedge i_clk); while (!o_rvalid);
    held_id   = o_rid;
    held_resp = o_rresp;
    held_data = o_rdata;
    compare_value("o_rid", held_id, 4'h8);
    compare_value("o_rdata", held_data, 32'h0bad_f00d);
    repeat (6) begin
      @(posedge i_clk);
      confirm(o_rvalid, "rvalid dropped while rready was low");
      compare_value("o_rid", o_rid, held_id);
      compare_value("o_rdata", o_rdata, held_data);
      compare_value("o_rresp", o_rresp, held_resp);
    end
    i_rready <= 1'b1;
    @(posedge i_clk);
    i_rready <= 1'b0;
    @(posedge i_clk);
    confirm(!o_rvalid, "rvalid stayed high after the R handshake");
  endtask

  initial begin
    i_arst_n  = 1'b0;
    i_awvalid = 1'b0;
    i_awid    = '0;
    i_awaddr  = '0;
    i_wvalid  = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_bready  = 1'b0;
    i_arvalid = 1'b0;
    i_arid    = '0;
    i_araddr  = '0;
    i_rready  = 1'b0;
    for (int t = 0; t < `TNOC_TARGETS; t++) begin
      i_m_awready[t] = 1'b0;
      i_m_wready[t]  = 1'b0;
      i_m_bvalid[t]  = 1'b0;
      i_m_bid[t]     = '0;
      i_m_bresp[t]   = '0;
      i_m_arready[t] = 1'b0;
      i_m_rvalid[t]  = 1'b0;
      i_m_rid[t]     = '0;
      i_m_rdata[t]   = '0;
      i_m_rresp[t]   = '0;
    end
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_arst_n <= 1'b1;
    @(posedge i_clk);
    test_reset_state();
    test_write_read();
    test_decode_error();
    test_forwarding();
    test_outstanding();
    test_backpressure();
    repeat (4) @(posedge i_clk);
    $display("Checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    repeat (RESET_CYCLES + 2 * NUM_TXNS * TXN_CYCLES) @(posedge i_clk);
    $display("Watchdog expired before all transactions completed, %0d errors", errors);
    $display("SIMULATION FAILED");
    $finish;
  end
endmodule

//--- tnoc_axi_bridge.f
+incdir+design
design/tnoc_pkg.sv
design/tnoc_flit_if.sv
design/tnoc_address_decoder.sv
design/tnoc_axi_slave_adapter.sv
design/tnoc_axi_master_adapter.sv
design/tnoc_fabric.sv
design/tnoc_axi_bridge.sv
tests/tnoc_axi_bridge_tb.sv
